/* logic/i2c_pkg.sv */
package i2c_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  count_t;
    typedef logic [15:0] divider_t;
    typedef logic [6:0]  dev_addr_t;

    // quarter-bit position inside one bus bit
    typedef logic [1:0]  phase_t;

    // one register transaction, 24 bits
    typedef struct packed {
        dev_addr_t dev_addr;
        logic      read;
        count_t    num_bytes;
        byte_t     reg_addr;
    } i2c_cmd_t;

    // bus levels, 1 on an output means released
    typedef struct packed {
        logic scl;
        logic sda;
    } i2c_line_t;

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_addr_w,
        st_addr_r,
        st_check_ack,
        st_reg_addr,
        st_restart,
        st_write_data,
        st_read_data,
        st_send_ack,
        st_send_nack,
        st_stop
    } seq_state_t;

    localparam int CMD_FIFO_DEPTH  = 2;
    localparam int DATA_FIFO_DEPTH = 4;

endpackage

/* logic/stream_fifo.sv */
`timescale 1ns/10ps

module stream_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clock,
    input  logic             reset_n,

    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,

    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] level_t;

    logic [WIDTH-1:0] mem [DEPTH];
    ptr_t             wr_ptr;
    ptr_t             rd_ptr;
    level_t           level;
    logic             push;
    logic             pop;

    // wrap at DEPTH, which need not be a power of two
    function automatic ptr_t ptr_next(input ptr_t ptr);
        return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready  = (level != level_t'(DEPTH));
    assign out_valid = (level != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // head entry shown directly
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // simultaneous push and pop keeps the level
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

/* logic/scl_tick_gen.sv */
`timescale 1ns/10ps

module scl_tick_gen (
    input  logic              clock,
    input  logic              reset_n,
    input  i2c_pkg::divider_t divider,
    input  logic              idle,
    input  logic              start_request,
    output logic              tick
);
    import i2c_pkg::*;

    divider_t count;

    // in idle only a waiting command makes a tick, at once
    assign tick = idle ? start_request : (count == '0);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (tick) begin
            count <= divider - 1'b1;
        end else if (!idle) begin
            count <= count - 1'b1;
        end
    end

endmodule

/* logic/i2c_bit_sequencer.sv */
`timescale 1ns/10ps

module i2c_bit_sequencer (
    input  logic               clock,
    input  logic               reset_n,
    input  logic               tick,

    input  logic               cmd_valid,
    input  i2c_pkg::i2c_cmd_t  cmd,
    output logic               cmd_ready,

    input  logic               wr_valid,
    input  i2c_pkg::byte_t     wr_data,
    output logic               wr_ready,

    output logic               rd_valid,
    output i2c_pkg::byte_t     rd_data,
    input  logic               rd_ready,

    input  i2c_pkg::i2c_line_t line_in,
    output i2c_pkg::i2c_line_t line_out,

    output logic               idle
);
    import i2c_pkg::*;

    localparam logic [2:0] BYTE_MSB = 3'd7;

    seq_state_t state;
    seq_state_t follow;
    phase_t     phase;
    logic [2:0] bit_cnt;
    count_t     byte_cnt;
    logic       nack;
    logic       abort;
    byte_t      tx_byte;

    ////////////////////////////////////////////////////////////
    // stream handshakes
    ////////////////////////////////////////////////////////////

    assign idle = (state == st_idle);

    // command stays at the FIFO head until STOP is done
    assign cmd_ready = tick && (state == st_stop) && (phase == 2'd3);

    // write byte popped after its last bit has gone out
    assign wr_ready = tick && (state == st_write_data) && (phase == 2'd3) && (bit_cnt == '0);

    // NACK before any data byte ends the transaction
    assign abort = nack && (byte_cnt == cmd.num_bytes);

    // byte being shifted out, MSB first
    always_comb begin
        case (state)
            st_addr_w:   tx_byte = {cmd.dev_addr, 1'b0};
            st_addr_r:   tx_byte = {cmd.dev_addr, 1'b1};
            st_reg_addr: tx_byte = cmd.reg_addr;
            default:     tx_byte = wr_data;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid <= 1'b0;
        end else if (tick && (state == st_read_data) && (phase == 2'd2) && (bit_cnt == '0)) begin
            rd_valid <= 1'b1;
        end else if (rd_ready) begin
            rd_valid <= 1'b0;
        end
    end

    // read bits land in place, no shifting needed
    always_ff @(posedge clock) begin
        if (tick && (state == st_read_data) && (phase == 2'd2)) begin
            rd_data[bit_cnt] <= line_in.sda;
        end
    end

    ////////////////////////////////////////////////////////////
    // bit FSM, one step per tick
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state    <= st_idle;
            follow   <= st_idle;
            phase    <= '0;
            bit_cnt  <= BYTE_MSB;
            byte_cnt <= '0;
            nack     <= 1'b0;
            line_out <= '{scl: 1'b1, sda: 1'b1};
        end else if (tick) begin
            if (state == st_idle) begin
                if (cmd_valid) begin
                    state    <= st_start;
                    phase    <= '0;
                    byte_cnt <= cmd.num_bytes;
                end
            end else begin
                case (phase)
                    2'd0: begin
                        line_out.scl <= 1'b1;
                        phase        <= 2'd1;
                    end
                    2'd1: begin
                        // target may be stretching the clock
                        if (line_in.scl) begin
                            phase <= 2'd2;
                            if (state == st_start || state == st_restart) begin
                                line_out.sda <= 1'b0;
                            end else if (state == st_stop) begin
                                line_out.sda <= 1'b1;
                            end
                        end
                    end
                    2'd2: begin
                        phase <= 2'd3;
                        if (state != st_stop) begin
                            line_out.scl <= 1'b0;
                        end
                        if (state == st_check_ack) begin
                            nack <= line_in.sda;
                        end
                    end
                    default: begin
                        case (state)
                            st_start, st_restart: begin
                                line_out.sda <= cmd.dev_addr[6];
                                bit_cnt      <= BYTE_MSB;
                                state        <= (state == st_start) ? st_addr_w : st_addr_r;
                                phase        <= '0;
                            end
                            st_addr_w, st_addr_r, st_reg_addr, st_write_data: begin
                                phase   <= '0;
                                bit_cnt <= bit_cnt - 1'b1;
                                if (bit_cnt == '0) begin
                                    // release SDA for the target ACK
                                    line_out.sda <= 1'b1;
                                    state        <= st_check_ack;
                                    case (state)
                                        st_addr_w: follow <= st_reg_addr;
                                        st_addr_r: follow <= st_read_data;
                                        st_reg_addr: begin
                                            follow <= cmd.read ? st_restart : st_write_data;
                                        end
                                        default: begin
                                            follow   <= (byte_cnt == 8'd1) ? st_stop
                                                                           : st_write_data;
                                            byte_cnt <= byte_cnt - 1'b1;
                                        end
                                    endcase
                                end else begin
                                    line_out.sda <= tx_byte[bit_cnt - 1'b1];
                                end
                            end
                            st_check_ack: begin
                                if (abort || follow == st_stop) begin
                                    line_out.sda <= 1'b0;
                                    state        <= st_stop;
                                    phase        <= '0;
                                end else if (follow == st_write_data) begin
                                    // hold SCL low until a write byte is there
                                    if (wr_valid) begin
                                        line_out.sda <= wr_data[7];
                                        state        <= st_write_data;
                                        bit_cnt      <= BYTE_MSB;
                                        phase        <= '0;
                                    end
                                end else if (follow == st_reg_addr) begin
                                    line_out.sda <= cmd.reg_addr[7];
                                    state        <= st_reg_addr;
                                    bit_cnt      <= BYTE_MSB;
                                    phase        <= '0;
                                end else begin
                                    // restart or read, both begin with SDA released
                                    line_out.sda <= 1'b1;
                                    state        <= follow;
                                    bit_cnt      <= BYTE_MSB;
                                    phase        <= '0;
                                end
                            end
                            st_read_data: begin
                                if (bit_cnt != '0) begin
                                    bit_cnt <= bit_cnt - 1'b1;
                                    phase   <= '0;
                                end else if (!rd_valid || rd_ready) begin
                                    bit_cnt  <= BYTE_MSB;
                                    byte_cnt <= byte_cnt - 1'b1;
                                    phase    <= '0;
                                    if (byte_cnt == 8'd1) begin
                                        line_out.sda <= 1'b1;
                                        state        <= st_send_nack;
                                    end else begin
                                        line_out.sda <= 1'b0;
                                        state        <= st_send_ack;
                                    end
                                end
                            end
                            st_send_ack: begin
                                line_out.sda <= 1'b1;
                                state        <= st_read_data;
                                phase        <= '0;
                            end
                            st_send_nack: begin
                                // SDA low so the STOP edge can follow
                                line_out.sda <= 1'b0;
                                state        <= st_stop;
                                phase        <= '0;
                            end
                            default: begin
                                state <= st_idle;
                                phase <= '0;
                            end
                        endcase
                    end
                endcase
            end
        end
    end

endmodule

/* logic/i2c_master_top.sv */
`timescale 1ns/10ps

module i2c_master_top (
    input  logic               clock,
    input  logic               reset_n,

    input  logic               s_cmd_valid,
    output logic               s_cmd_ready,
    input  i2c_pkg::i2c_cmd_t  s_cmd,

    input  logic               s_wr_valid,
    output logic               s_wr_ready,
    input  i2c_pkg::byte_t     s_wr_data,

    output logic               m_rd_valid,
    input  logic               m_rd_ready,
    output i2c_pkg::byte_t     m_rd_data,

    input  i2c_pkg::divider_t  divider,

    input  i2c_pkg::i2c_line_t line_in,
    output i2c_pkg::i2c_line_t line_out
);
    import i2c_pkg::*;

    i2c_cmd_t cmd;
    logic     cmd_valid;
    logic     cmd_ready;
    byte_t    wr_data;
    logic     wr_valid;
    logic     wr_ready;
    byte_t    rd_data;
    logic     rd_valid;
    logic     rd_ready;
    logic     tick;
    logic     idle;

    ////////////////////////////////////////////////////////////
    // input side
    ////////////////////////////////////////////////////////////

    stream_fifo #(.WIDTH($bits(i2c_cmd_t)), .DEPTH(CMD_FIFO_DEPTH)) cmd_fifo (
        .clock     (clock),
        .reset_n   (reset_n),
        .in_valid  (s_cmd_valid),
        .in_ready  (s_cmd_ready),
        .in_data   (s_cmd),
        .out_valid (cmd_valid),
        .out_ready (cmd_ready),
        .out_data  (cmd)
    );

    stream_fifo #(.WIDTH($bits(byte_t)), .DEPTH(DATA_FIFO_DEPTH)) wr_fifo (
        .clock     (clock),
        .reset_n   (reset_n),
        .in_valid  (s_wr_valid),
        .in_ready  (s_wr_ready),
        .in_data   (s_wr_data),
        .out_valid (wr_valid),
        .out_ready (wr_ready),
        .out_data  (wr_data)
    );

    ////////////////////////////////////////////////////////////
    // bus timing and sequencing
    ////////////////////////////////////////////////////////////

    scl_tick_gen u_tick_gen (
        .clock         (clock),
        .reset_n       (reset_n),
        .divider       (divider),
        .idle          (idle),
        .start_request (cmd_valid),
        .tick          (tick)
    );

    i2c_bit_sequencer u_sequencer (
        .clock     (clock),
        .reset_n   (reset_n),
        .tick      (tick),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .wr_valid  (wr_valid),
        .wr_data   (wr_data),
        .wr_ready  (wr_ready),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .rd_ready  (rd_ready),
        .line_in   (line_in),
        .line_out  (line_out),
        .idle      (idle)
    );

    // output side
    stream_fifo #(.WIDTH($bits(byte_t)), .DEPTH(DATA_FIFO_DEPTH)) rd_fifo (
        .clock     (clock),
        .reset_n   (reset_n),
        .in_valid  (rd_valid),
        .in_ready  (rd_ready),
        .in_data   (rd_data),
        .out_valid (m_rd_valid),
        .out_ready (m_rd_ready),
        .out_data  (m_rd_data)
    );

endmodule

/* sim/i2c_target_model.sv */
`timescale 1ns/10ps

module i2c_target_model #(
    parameter logic [6:0] DEV_ADDR = 7'h2A
) (
    input  logic clock,
    input  logic scl,
    input  logic sda,
    output logic scl_drive,
    output logic sda_drive
);

    // log entry {kind, ack, byte}: 0 byte, 1 START, 2 repeated START, 3 STOP
    logic [10:0] log_q[$];
    logic [7:0]  regs[256];
    logic        nack_addr = 1'b0;
    int          stretch_max = 0;
    int          stops = 0;
    integer      seed = 56;
    logic        busy = 1'b0;
    logic        rw = 1'b0;
    logic        ack_bit = 1'b1;
    int          bit_n = 0;
    int          byte_idx = 0;
    int          stretch;
    logic [7:0]  shreg = '0;
    logic [7:0]  reg_ptr = '0;
    logic [7:0]  tx = '1;

    initial begin
        scl_drive = 1'b1;
        sda_drive = 1'b1;
        for (int i = 0; i < 256; i++) begin
            regs[i] = 8'(i) ^ 8'h5A;
        end
    end

    // START and STOP both happen with SCL high
    always @(negedge sda) begin
        if (scl) begin
            log_q.push_back({busy ? 2'd2 : 2'd1, 1'b0, 8'h00});
            busy     = 1'b1;
            rw       = 1'b0;
            bit_n    = 0;
            byte_idx = 0;
        end
    end

    always @(posedge sda) begin
        if (scl) begin
            log_q.push_back({2'd3, 1'b0, 8'h00});
            busy  = 1'b0;
            rw    = 1'b0;
            bit_n = 0;
            stops++;
        end
    end

    always @(posedge scl) begin
        if (bit_n < 8) begin
            shreg = {shreg[6:0], sda};
            bit_n++;
        end else if (bit_n == 8) begin
            // ninth clock carries the ACK bit
            ack_bit = sda;
            log_q.push_back({2'd0, ack_bit, shreg});
            if (!rw) begin
                if (byte_idx == 0) begin
                    rw = !ack_bit && shreg[0];
                end else if (byte_idx == 1) begin
                    reg_ptr = shreg;
                end else begin
                    regs[reg_ptr] = shreg;
                    reg_ptr++;
                end
            end
            byte_idx++;
            bit_n = 9;
        end
    end

    always @(negedge scl) begin
        if (bit_n == 9) begin
            bit_n = 0;
            if (rw && !ack_bit) begin
                tx = regs[reg_ptr];
                reg_ptr++;
                sda_drive = tx[7];
            end else begin
                sda_drive = 1'b1;
            end
        end else if (bit_n == 8) begin
            if (rw) begin
                sda_drive = 1'b1;
            end else if (byte_idx != 0 || (shreg[7:1] == DEV_ADDR && !nack_addr)) begin
                sda_drive = 1'b0;
            end
        end else if (rw && bit_n > 0) begin
            sda_drive = tx[7 - bit_n];
        end
    end

    // clock stretch after each falling SCL
    always @(negedge scl) begin
        if (stretch_max > 0) begin
            stretch = $unsigned($random(seed)) % (stretch_max + 1);
            scl_drive = 1'b0;
            repeat (stretch) @(posedge clock);
            scl_drive = 1'b1;
        end
    end

endmodule

/* sim/tb_i2c_master.sv */
`timescale 1ns/10ps

module tb_i2c_master;
    import i2c_pkg::*;

    localparam int        DIV          = 4;
    localparam dev_addr_t DEV          = 7'h2A;
    localparam int        BUS_BITS     = 360;
    localparam int        STRETCH_BITS = 120;
    localparam int        STALL_CYCLES = 100;
    localparam int        LIMIT_CYCLES = 2 * (BUS_BITS * 4 * DIV + STRETCH_BITS * 20
                                              + STALL_CYCLES + 16);

    logic      clock = 1'b0;
    logic      reset_n = 1'b0;
    logic      s_cmd_valid = 1'b0;
    logic      s_cmd_ready;
    i2c_cmd_t  s_cmd = '0;
    logic      s_wr_valid = 1'b0;
    logic      s_wr_ready;
    byte_t     s_wr_data = '0;
    logic      m_rd_valid;
    logic      m_rd_ready = 1'b0;
    byte_t     m_rd_data;
    divider_t  divider = DIV;
    i2c_line_t line_in;
    i2c_line_t line_out;
    logic      model_scl;
    logic      model_sda;

    integer      seed = 56;
    int          errors = 0;
    int          passed = 0;
    int          failed = 0;
    int          e0;
    byte_t       rd_bytes[$];
    logic [10:0] exp_log[$];

    always #20 clock = ~clock;

    // wired-AND bus
    assign line_in.scl = line_out.scl & model_scl;
    assign line_in.sda = line_out.sda & model_sda;

    i2c_master_top UUT (
        .clock       (clock),
        .reset_n     (reset_n),
        .s_cmd_valid (s_cmd_valid),
        .s_cmd_ready (s_cmd_ready),
        .s_cmd       (s_cmd),
        .s_wr_valid  (s_wr_valid),
        .s_wr_ready  (s_wr_ready),
        .s_wr_data   (s_wr_data),
        .m_rd_valid  (m_rd_valid),
        .m_rd_ready  (m_rd_ready),
        .m_rd_data   (m_rd_data),
        .divider     (divider),
        .line_in     (line_in),
        .line_out    (line_out)
    );

    i2c_target_model #(.DEV_ADDR(DEV)) target (
        .clock     (clock),
        .scl       (line_in.scl),
        .sda       (line_in.sda),
        .scl_drive (model_scl),
        .sda_drive (model_sda)
    );

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_reset_outputs();
        check_val("line_out", 2'b11, line_out);
        check_val("m_rd_valid", 0, m_rd_valid);
        check_val("s_cmd_ready", 1, s_cmd_ready);
        check_val("s_wr_ready", 1, s_wr_ready);
    endtask

    always @(negedge clock) begin
        if (!reset_n) begin
            check_reset_outputs();
        end
    end

    function automatic void log_expect(input logic [1:0] kind, input logic ack, input byte_t b);
        exp_log.push_back({kind, ack, b});
    endfunction

    task automatic compare_log();
        check_val("bus_log.size", exp_log.size(), target.log_q.size());
        for (int i = 0; i < exp_log.size() && i < target.log_q.size(); i++) begin
            check_val($sformatf("bus_log[%0d]", i), exp_log[i], target.log_q[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stream drivers on the falling edge
    ////////////////////////////////////////////////////////////

    task automatic send_cmd(input logic rd, input count_t n, input byte_t r);
        @(negedge clock);
        s_cmd = '{dev_addr: DEV, read: rd, num_bytes: n, reg_addr: r};
        s_cmd_valid = 1'b1;
        while (!s_cmd_ready) @(negedge clock);
        @(negedge clock);
        s_cmd_valid = 1'b0;
    endtask

    task automatic send_byte(input byte_t b);
        @(negedge clock);
        s_wr_data = b;
        s_wr_valid = 1'b1;
        while (!s_wr_ready) @(negedge clock);
        @(negedge clock);
        s_wr_valid = 1'b0;
    endtask

    task automatic collect(input int n);
        @(negedge clock);
        m_rd_ready = 1'b1;
        while (rd_bytes.size() < n) begin
            if (m_rd_valid) begin
                rd_bytes.push_back(m_rd_data);
            end
            @(negedge clock);
        end
        m_rd_ready = 1'b0;
    endtask

    task automatic run_write(input byte_t r, input int n);
        byte_t data[$];
        byte_t b;
        int    stops0;
        exp_log.delete();
        target.log_q.delete();
        stops0 = target.stops;
        log_expect(2'd1, 1'b0, 8'h00);
        log_expect(2'd0, 1'b0, {DEV, 1'b0});
        log_expect(2'd0, 1'b0, r);
        for (int i = 0; i < n; i++) begin
            b = byte_t'($random(seed));
            data.push_back(b);
            log_expect(2'd0, 1'b0, b);
        end
        log_expect(2'd3, 1'b0, 8'h00);
        send_cmd(1'b0, count_t'(n), r);
        foreach (data[i]) begin
            send_byte(data[i]);
        end
        wait (target.stops > stops0);
        compare_log();
        foreach (data[i]) begin
            check_val("target.regs", data[i], target.regs[8'(r + i)]);
        end
    endtask

    task automatic run_read(input byte_t r, input int n, input logic stall);
        int stops0;
        exp_log.delete();
        target.log_q.delete();
        rd_bytes.delete();
        stops0 = target.stops;
        log_expect(2'd1, 1'b0, 8'h00);
        log_expect(2'd0, 1'b0, {DEV, 1'b0});
        log_expect(2'd0, 1'b0, r);
        log_expect(2'd2, 1'b0, 8'h00);
        log_expect(2'd0, 1'b0, {DEV, 1'b1});
        for (int i = 0; i < n; i++) begin
            log_expect(2'd0, i == n - 1, 8'(r + i) ^ 8'h5A);
        end
        log_expect(2'd3, 1'b0, 8'h00);
        send_cmd(1'b1, count_t'(n), r);
        if (stall) begin
            // sequencer parked with SCL low while the read FIFO is full
            wait (UUT.rd_valid && !UUT.rd_ready);
            repeat (STALL_CYCLES) begin
                @(negedge clock);
                check_val("line_in.scl", 0, line_in.scl);
            end
        end
        collect(n);
        wait (target.stops > stops0);
        compare_log();
        for (int i = 0; i < n; i++) begin
            check_val("m_rd_data", 8'(r + i) ^ 8'h5A, rd_bytes[i]);
        end
    endtask

    // target ignores its address, the master must stop right after the ACK slot
    task automatic run_addr_nack(input byte_t r);
        int stops0;
        exp_log.delete();
        target.log_q.delete();
        stops0 = target.stops;
        target.nack_addr = 1'b1;
        log_expect(2'd1, 1'b0, 8'h00);
        log_expect(2'd0, 1'b1, {DEV, 1'b0});
        log_expect(2'd3, 1'b0, 8'h00);
        send_cmd(1'b1, 8'd2, r);
        wait (target.stops > stops0);
        compare_log();
        check_val("m_rd_valid", 0, m_rd_valid);
        target.nack_addr = 1'b0;
    endtask

    task automatic end_test(input string name);
        if (errors == e0) begin
            passed++;
            $display("%s: passed", name);
        end else begin
            failed++;
            $display("%s: failed with %0d errors", name, errors - e0);
        end
        e0 = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        e0 = 0;
        repeat (16) @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);
        check_reset_outputs();
        end_test("reset");

        run_write(8'h10, 3);
        end_test("write transaction");

        run_read(8'h40, 4, 1'b0);
        end_test("read transaction");

        run_addr_nack(8'h50);
        run_write(8'h30, 2);
        end_test("address nack abort");

        target.stretch_max = 20;
        run_write(8'h20, 3);
        run_read(8'h60, 4, 1'b0);
        target.stretch_max = 0;
        end_test("clock stretching");

        run_read(8'h80, 6, 1'b1);
        end_test("read back-pressure");

        $display("tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(LIMIT_CYCLES * 40);
        $display("timeout: the bus did not finish within %0d cycles", LIMIT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* vlog.f */
logic/i2c_pkg.sv
logic/stream_fifo.sv
logic/scl_tick_gen.sv
logic/i2c_bit_sequencer.sv
logic/i2c_master_top.sv
sim/i2c_target_model.sv
sim/tb_i2c_master.sv
